// ==== rv_decode_pkg.sv ====
// RV32I base set only: every instruction is 32 bits, no CSRs, no compressed or extension opcodes
package rv_decode_pkg;

	// ----------------------------------------------------------------------
	// Widths and fixed values
	// ----------------------------------------------------------------------

	localparam int unsigned XLEN  = 32;
	localparam int unsigned REG_W = 5;

	typedef logic [XLEN-1:0]  addr_t;
	typedef logic [REG_W-1:0] reg_idx_t;

	localparam addr_t RESET_VECTOR = 32'h0000_0040;
	// Both the sequential PC step and the link value, since every instruction is one word
	localparam addr_t INSTR_STEP   = 32'h0000_0004;

	// ----------------------------------------------------------------------
	// Instruction word views
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0] imm20;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		u_fmt_t u_fmt;
	} rv_instr_u;

	// Major opcodes, including the two always-set low bits
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// funct7 of the plain and the alternate (SUB, SRA) ALU forms
	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

	// SYSTEM instructions are told apart by the I-type immediate
	localparam logic [11:0] IMM12_ECALL  = 12'h000;
	localparam logic [11:0] IMM12_EBREAK = 12'h001;
	localparam logic [11:0] IMM12_MRET   = 12'h302;

	// ----------------------------------------------------------------------
	// Execute-stage control encodings
	// ----------------------------------------------------------------------

	typedef enum logic {ALUSRC_A_RS1 = 1'b0, ALUSRC_A_PC  = 1'b1} alusrc_a_e;
	typedef enum logic {ALUSRC_B_RS2 = 1'b0, ALUSRC_B_IMM = 1'b1} alusrc_b_e;

	typedef enum logic [3:0] {
		ALUOP_ADD = 4'd0, ALUOP_SUB = 4'd1, ALUOP_SLL = 4'd2, ALUOP_LT  = 4'd3,
		ALUOP_LTU = 4'd4, ALUOP_XOR = 4'd5, ALUOP_SRL = 4'd6, ALUOP_SRA = 4'd7,
		ALUOP_OR  = 4'd8, ALUOP_AND = 4'd9, ALUOP_RS2 = 4'd10
	} aluop_e;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'd0, MEMOP_LB  = 4'd1, MEMOP_LH  = 4'd2, MEMOP_LW = 4'd3,
		MEMOP_LBU  = 4'd4, MEMOP_LHU = 4'd5, MEMOP_SB  = 4'd6, MEMOP_SH = 4'd7,
		MEMOP_SW   = 4'd8
	} memop_e;

	typedef enum logic [1:0] {
		BCOND_NEVER = 2'd0, BCOND_ALWAYS = 2'd1, BCOND_ZERO = 2'd2, BCOND_NZERO = 2'd3
	} bcond_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE    = 3'd0, EXCEPT_INSTR_FAULT = 3'd1, EXCEPT_INSTR_ILLEGAL = 3'd2,
		EXCEPT_ECALL_M = 3'd3, EXCEPT_ECALL_U     = 3'd4, EXCEPT_EBREAK        = 3'd5,
		EXCEPT_MRET    = 3'd6
	} except_e;

endpackage

// ==== pc_cir_ctrl.sv ====
// cir_vld_i counts valid halfwords (0 to 2); the PC only ever steps by one word or loads a jump target
module pc_cir_ctrl
	import rv_decode_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [1:0] cir_vld_i,
	input  logic [1:0] cir_err_i,
	input  logic       x_stall_i,
	input  logic       jump_now_i,
	input  logic       jump_not_except_i,
	input  addr_t      jump_target_i,
	output addr_t      pc_o,
	output logic [1:0] cir_use_o,
	output logic       cir_flush_behind_o,
	output logic       starved_o,
	output logic       bus_fault_o,
	output logic       lock_prev_o
);

logic  starved;
logic  stall;
logic  jump_by_d;
logic  assert_lock;
logic  lock;
logic  lock_prev;
addr_t pc;

// ----------------------------------------------------------------------
// Stall and fetch fault
// ----------------------------------------------------------------------

// A full instruction needs both halfwords of the CIR
assign starved = cir_vld_i < 2'd2;
assign stall   = x_stall_i || starved;

// An error flag only counts for a halfword that is actually valid
assign bus_fault_o = (cir_vld_i > 2'd0 && cir_err_i[0]) ||
	(cir_vld_i > 2'd1 && cir_err_i[1]);

assign cir_use_o = stall ? 2'd0 : 2'd2;
assign starved_o = starved;

// ----------------------------------------------------------------------
// CIR lock
// ----------------------------------------------------------------------

// When this instruction's jump goes out while decode is stalled, the
// frontend must keep the CIR and refill behind it, so the instruction can
// finish its remaining work (the link write) once the stall clears
assign jump_by_d   = jump_now_i && jump_not_except_i;
assign assert_lock = jump_by_d && stall;
assign lock        = (lock_prev && stall) || assert_lock;

assign cir_flush_behind_o = assert_lock && !lock_prev;
assign lock_prev_o        = lock_prev;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		lock_prev <= 1'b0;
	end else begin
		lock_prev <= lock;
	end
end

// ----------------------------------------------------------------------
// PC sequencing
// ----------------------------------------------------------------------

// On lock release the PC picks up the target that was issued while stalled
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pc <= RESET_VECTOR;
	end else if ((jump_now_i && !assert_lock) || (lock_prev && !stall)) begin
		pc <= jump_target_i;
	end else if (!stall && !lock) begin
		pc <= pc + INSTR_STEP;
	end
end

assign pc_o = pc;

endmodule

// ==== imm_gen.sv ====
// Purely combinational; selection looks at the opcode only, so illegal words still yield some immediate
module imm_gen
	import rv_decode_pkg::*;
(
	input  rv_instr_u instr_i,
	output addr_t     imm_o,
	output addr_t     addr_offs_o
);

logic [XLEN-1:0] word;
logic [6:0]      opcode;
addr_t           imm_i;
addr_t           imm_s;
addr_t           imm_b;
addr_t           imm_u;
addr_t           imm_j;

assign word   = instr_i;
assign opcode = instr_i.r_fmt.opcode;

// ----------------------------------------------------------------------
// Immediate formats
// ----------------------------------------------------------------------

assign imm_i = {{20{instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
assign imm_s = {{21{word[31]}}, word[30:25], word[11:7]};
// B and J keep bit 0 clear since targets are halfword aligned
assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
assign imm_u = {instr_i.u_fmt.imm20, 12'h000};
assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

// ----------------------------------------------------------------------
// Selection
// ----------------------------------------------------------------------

// Jumps put the link value on the operand path, PC + INSTR_STEP
always_comb begin
	case (opcode)
		OPC_LUI, OPC_AUIPC: imm_o = imm_u;
		OPC_JAL, OPC_JALR:  imm_o = INSTR_STEP;
		default:            imm_o = imm_i;
	endcase
end

// The address adder works beside the ALU
always_comb begin
	case (opcode)
		OPC_JAL:            addr_offs_o = imm_j;
		OPC_BRANCH:         addr_offs_o = imm_b;
		OPC_STORE:          addr_offs_o = imm_s;
		OPC_JALR, OPC_LOAD: addr_offs_o = imm_i;
		default:            addr_offs_o = '0;
	endcase
end

endmodule

// ==== instr_decoder.sv ====
// Decodes RV32I plus ECALL, EBREAK and MRET; any other encoding, CSR ops included, raises illegal
module instr_decoder
	import rv_decode_pkg::*;
(
	input  rv_instr_u instr_i,
	input  logic      m_mode_i,
	input  logic      starved_i,
	input  logic      bus_fault_i,
	input  logic      lock_prev_i,
	output reg_idx_t  rs1_o,
	output reg_idx_t  rs2_o,
	output reg_idx_t  rd_o,
	output alusrc_a_e alusrc_a_o,
	output alusrc_b_e alusrc_b_o,
	output aluop_e    aluop_o,
	output memop_e    memop_o,
	output bcond_e    branchcond_o,
	output logic      addr_is_regoffs_o,
	output except_e   except_o
);

logic [6:0]  opcode;
logic [2:0]  funct3;
logic [6:0]  funct7;
logic [11:0] imm12;
logic        fixed_zero;
logic        illegal;

assign opcode = instr_i.r_fmt.opcode;
assign funct3 = instr_i.r_fmt.funct3;
assign funct7 = instr_i.r_fmt.funct7;
assign imm12  = instr_i.i_fmt.imm12;

// FENCE and SYSTEM words carry zero rs1, funct3 and rd
assign fixed_zero = instr_i.i_fmt.rs1 == '0 && funct3 == 3'b000 && instr_i.i_fmt.rd == '0;

// The alternate bit only matters for funct3 000 (SUB) and 101 (SRA)
function automatic aluop_e alu_by_funct3(input logic [2:0] f3, input logic alt);
	case (f3)
		3'b000:  return alt ? ALUOP_SUB : ALUOP_ADD;
		3'b001:  return ALUOP_SLL;
		3'b010:  return ALUOP_LT;
		3'b011:  return ALUOP_LTU;
		3'b100:  return ALUOP_XOR;
		3'b101:  return alt ? ALUOP_SRA : ALUOP_SRL;
		3'b110:  return ALUOP_OR;
		default: return ALUOP_AND;
	endcase
endfunction

// ----------------------------------------------------------------------
// Execute controls
// ----------------------------------------------------------------------

always_comb begin
	rs1_o             = instr_i.r_fmt.rs1;
	rs2_o             = instr_i.r_fmt.rs2;
	rd_o              = instr_i.r_fmt.rd;
	alusrc_a_o        = ALUSRC_A_RS1;
	alusrc_b_o        = ALUSRC_B_RS2;
	aluop_o           = ALUOP_ADD;
	memop_o           = MEMOP_NONE;
	branchcond_o      = BCOND_NEVER;
	addr_is_regoffs_o = 1'b0;
	except_o          = EXCEPT_NONE;
	illegal           = 1'b0;

	case (opcode)
		OPC_BRANCH: begin
			rd_o = '0;
			// Bit 0 inverts the sense, bits 2:1 pick the comparison
			case (funct3[2:1])
				2'b00:   aluop_o = ALUOP_SUB;
				2'b10:   aluop_o = ALUOP_LT;
				2'b11:   aluop_o = ALUOP_LTU;
				default: illegal = 1'b1;
			endcase
			// BEQ and BNE compare by subtraction, so for them the sense flips
			if (funct3[2:1] == 2'b00) begin
				branchcond_o = funct3[0] ? BCOND_NZERO : BCOND_ZERO;
			end else begin
				branchcond_o = funct3[0] ? BCOND_ZERO : BCOND_NZERO;
			end
		end
		OPC_JAL: begin
			rs1_o        = '0;
			rs2_o        = '0;
			alusrc_a_o   = ALUSRC_A_PC;
			alusrc_b_o   = ALUSRC_B_IMM;
			branchcond_o = BCOND_ALWAYS;
		end
		OPC_JALR: begin
			rs2_o             = '0;
			alusrc_a_o        = ALUSRC_A_PC;
			alusrc_b_o        = ALUSRC_B_IMM;
			branchcond_o      = BCOND_ALWAYS;
			addr_is_regoffs_o = 1'b1;
			illegal           = funct3 != 3'b000;
		end
		OPC_LUI: begin
			rs1_o      = '0;
			rs2_o      = '0;
			aluop_o    = ALUOP_RS2;
			alusrc_b_o = ALUSRC_B_IMM;
		end
		OPC_AUIPC: begin
			rs1_o      = '0;
			rs2_o      = '0;
			alusrc_a_o = ALUSRC_A_PC;
			alusrc_b_o = ALUSRC_B_IMM;
		end
		OPC_OP_IMM: begin
			rs2_o      = '0;
			alusrc_b_o = ALUSRC_B_IMM;
			aluop_o    = alu_by_funct3(funct3, funct3 == 3'b101 && funct7 == FUNCT7_ALT);
			// Shift amounts leave only funct7 in the upper immediate bits
			if (funct3 == 3'b001) begin
				illegal = funct7 != FUNCT7_BASE;
			end else if (funct3 == 3'b101) begin
				illegal = funct7 != FUNCT7_BASE && funct7 != FUNCT7_ALT;
			end
		end
		OPC_OP: begin
			aluop_o = alu_by_funct3(funct3, funct7 == FUNCT7_ALT);
			if (funct7 == FUNCT7_ALT) begin
				illegal = funct3 != 3'b000 && funct3 != 3'b101;
			end else begin
				illegal = funct7 != FUNCT7_BASE;
			end
		end
		OPC_LOAD: begin
			rs2_o             = '0;
			addr_is_regoffs_o = 1'b1;
			case (funct3)
				3'b000:  memop_o = MEMOP_LB;
				3'b001:  memop_o = MEMOP_LH;
				3'b010:  memop_o = MEMOP_LW;
				3'b100:  memop_o = MEMOP_LBU;
				3'b101:  memop_o = MEMOP_LHU;
				default: illegal = 1'b1;
			endcase
		end
		OPC_STORE: begin
			rd_o              = '0;
			aluop_o           = ALUOP_RS2;
			addr_is_regoffs_o = 1'b1;
			case (funct3)
				3'b000:  memop_o = MEMOP_SB;
				3'b001:  memop_o = MEMOP_SH;
				3'b010:  memop_o = MEMOP_SW;
				default: illegal = 1'b1;
			endcase
		end
		OPC_MISC_MEM: begin
			// FENCE has nothing to order in this core and passes as a no-op
			rs2_o   = '0;
			illegal = !fixed_zero;
		end
		OPC_SYSTEM: begin
			rs1_o = '0;
			rs2_o = '0;
			rd_o  = '0;
			if (!fixed_zero) begin
				illegal = 1'b1;
			end else if (imm12 == IMM12_ECALL) begin
				except_o = m_mode_i ? EXCEPT_ECALL_M : EXCEPT_ECALL_U;
			end else if (imm12 == IMM12_EBREAK) begin
				except_o = EXCEPT_EBREAK;
			end else if (imm12 == IMM12_MRET && m_mode_i) begin
				except_o = EXCEPT_MRET;
			end else begin
				illegal = 1'b1;
			end
		end
		default: illegal = 1'b1;
	endcase

	// Squash anything that must not reach execute; a fetch fault wins over illegal
	if (illegal || starved_i || bus_fault_i) begin
		rs1_o        = '0;
		rs2_o        = '0;
		rd_o         = '0;
		memop_o      = MEMOP_NONE;
		branchcond_o = BCOND_NEVER;
		aluop_o      = ALUOP_ADD;
		if (bus_fault_i) begin
			except_o = EXCEPT_INSTR_FAULT;
		end else if (illegal && !starved_i) begin
			except_o = EXCEPT_INSTR_ILLEGAL;
		end else begin
			except_o = EXCEPT_NONE;
		end
	end
	// A locked CIR has already issued its jump
	if (lock_prev_i) begin
		branchcond_o = BCOND_NEVER;
	end
end

endmodule

// ==== rv_decode.sv ====
// Single instruction in decode, no pipelining; all decode outputs are combinational, pc_o is registered
module rv_decode
	import rv_decode_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Fetch buffer side
	input  logic [31:0] cir_i,
	input  logic [1:0]  cir_err_i,
	input  logic [1:0]  cir_vld_i,
	output logic [1:0]  cir_use_o,
	output logic        cir_flush_behind_o,
	output addr_t       pc_o,

	input  logic        m_mode_i,

	// Execute side
	output logic        starved_o,
	input  logic        x_stall_i,
	input  logic        jump_now_i,
	input  addr_t       jump_target_i,
	input  logic        jump_not_except_i,

	output addr_t       imm_o,
	output reg_idx_t    rs1_o,
	output reg_idx_t    rs2_o,
	output reg_idx_t    rd_o,
	output alusrc_a_e   alusrc_a_o,
	output alusrc_b_e   alusrc_b_o,
	output aluop_e      aluop_o,
	output memop_e      memop_o,
	output bcond_e      branchcond_o,
	output addr_t       addr_offs_o,
	output logic        addr_is_regoffs_o,
	output except_e     except_o
);

rv_instr_u instr;
logic      starved;
logic      bus_fault;
logic      lock_prev;

assign instr     = rv_instr_u'(cir_i);
assign starved_o = starved;

// ----------------------------------------------------------------------
// PC and CIR control
// ----------------------------------------------------------------------

pc_cir_ctrl i_pc_cir_ctrl (
	.clk                (clk),
	.rst_n              (rst_n),
	.cir_vld_i          (cir_vld_i),
	.cir_err_i          (cir_err_i),
	.x_stall_i          (x_stall_i),
	.jump_now_i         (jump_now_i),
	.jump_not_except_i  (jump_not_except_i),
	.jump_target_i      (jump_target_i),
	.pc_o               (pc_o),
	.cir_use_o          (cir_use_o),
	.cir_flush_behind_o (cir_flush_behind_o),
	.starved_o          (starved),
	.bus_fault_o        (bus_fault),
	.lock_prev_o        (lock_prev)
);

// ----------------------------------------------------------------------
// Immediates and execute controls
// ----------------------------------------------------------------------

imm_gen i_imm_gen (
	.instr_i     (instr),
	.imm_o       (imm_o),
	.addr_offs_o (addr_offs_o)
);

instr_decoder i_instr_decoder (
	.instr_i           (instr),
	.m_mode_i          (m_mode_i),
	.starved_i         (starved),
	.bus_fault_i       (bus_fault),
	.lock_prev_i       (lock_prev),
	.rs1_o             (rs1_o),
	.rs2_o             (rs2_o),
	.rd_o              (rd_o),
	.alusrc_a_o        (alusrc_a_o),
	.alusrc_b_o        (alusrc_b_o),
	.aluop_o           (aluop_o),
	.memop_o           (memop_o),
	.branchcond_o      (branchcond_o),
	.addr_is_regoffs_o (addr_is_regoffs_o),
	.except_o          (except_o)
);

endmodule

// ==== tb_decode_model.svh ====
// Reference decode and PC/lock model; expects cir_vld_i in 0..2 and is included inside the testbench

typedef struct packed {
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	reg_idx_t  rd;
	alusrc_a_e src_a;
	alusrc_b_e src_b;
	aluop_e    aluop;
	memop_e    memop;
	bcond_e    bcond;
	logic      regoffs;
	except_e   except;
	logic      starved;
	addr_t     imm;
	addr_t     offs;
} exp_dec_t;

// Expected decode outputs of one word, following the decode rule table
function automatic exp_dec_t expected_decode(input logic [31:0] w, input logic m_mode,
	input logic [1:0] vld, input logic [1:0] err, input logic lock_prev);
	exp_dec_t   e;
	logic [2:0] f3;
	logic [6:0] f7;
	logic       ill;
	logic       fault;
	logic       zero_fields;
	aluop_e     base_ops [8];
	memop_e     loads [8];
	base_ops = '{ALUOP_ADD, ALUOP_SLL, ALUOP_LT, ALUOP_LTU,
		ALUOP_XOR, ALUOP_SRL, ALUOP_OR, ALUOP_AND};
	loads = '{MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_NONE,
		MEMOP_LBU, MEMOP_LHU, MEMOP_NONE, MEMOP_NONE};
	f3 = w[14:12];
	f7 = w[31:25];
	// rs1, funct3 and rd together
	zero_fields = w[19:7] == 13'd0;
	ill = 1'b0;
	e = '0;
	e.rs1 = w[19:15];
	e.rs2 = w[24:20];
	e.rd = w[11:7];
	e.starved = vld < 2'd2;
	e.imm = {{20{w[31]}}, w[31:20]};
	case (w[6:0])
		OPC_OP: begin
			ill = !(f7 == FUNCT7_BASE || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
			e.aluop = (f7 == FUNCT7_ALT) ? ((f3 == 3'd0) ? ALUOP_SUB : ALUOP_SRA) : base_ops[f3];
		end
		OPC_OP_IMM: begin
			e.rs2 = '0;
			e.src_b = ALUSRC_B_IMM;
			ill = (f3 == 3'd1 && f7 != FUNCT7_BASE) ||
				(f3 == 3'd5 && f7 != FUNCT7_BASE && f7 != FUNCT7_ALT);
			e.aluop = (f3 == 3'd5 && f7 == FUNCT7_ALT) ? ALUOP_SRA : base_ops[f3];
		end
		OPC_LUI, OPC_AUIPC: begin
			e.rs1 = '0;
			e.rs2 = '0;
			e.src_b = ALUSRC_B_IMM;
			e.imm = {w[31:12], 12'h000};
			if (w[6:0] == OPC_LUI) begin
				e.aluop = ALUOP_RS2;
			end else begin
				e.src_a = ALUSRC_A_PC;
			end
		end
		OPC_LOAD: begin
			e.rs2 = '0;
			e.regoffs = 1'b1;
			e.memop = loads[f3];
			ill = loads[f3] == MEMOP_NONE;
			e.offs = {{20{w[31]}}, w[31:20]};
		end
		OPC_STORE: begin
			e.rd = '0;
			e.aluop = ALUOP_RS2;
			e.regoffs = 1'b1;
			e.memop = (f3 == 3'd0) ? MEMOP_SB : ((f3 == 3'd1) ? MEMOP_SH : MEMOP_SW);
			ill = f3 > 3'd2;
			e.offs = {{20{w[31]}}, w[31:25], w[11:7]};
		end
		OPC_BRANCH: begin
			e.rd = '0;
			ill = f3[2:1] == 2'b01;
			e.aluop = f3[2] ? (f3[1] ? ALUOP_LTU : ALUOP_LT) : ALUOP_SUB;
			e.bcond = (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7) ? BCOND_ZERO : BCOND_NZERO;
			e.offs = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		end
		OPC_JAL, OPC_JALR: begin
			e.rs2 = '0;
			e.src_a = ALUSRC_A_PC;
			e.src_b = ALUSRC_B_IMM;
			e.bcond = BCOND_ALWAYS;
			e.imm = INSTR_STEP;
			if (w[6:0] == OPC_JAL) begin
				e.rs1 = '0;
				e.offs = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			end else begin
				e.regoffs = 1'b1;
				ill = f3 != 3'd0;
				e.offs = {{20{w[31]}}, w[31:20]};
			end
		end
		OPC_MISC_MEM: begin
			e.rs2 = '0;
			ill = !zero_fields;
		end
		OPC_SYSTEM: begin
			e.rs1 = '0;
			e.rs2 = '0;
			e.rd = '0;
			if (!zero_fields) begin
				ill = 1'b1;
			end else if (w[31:20] == IMM12_ECALL) begin
				e.except = m_mode ? EXCEPT_ECALL_M : EXCEPT_ECALL_U;
			end else if (w[31:20] == IMM12_EBREAK) begin
				e.except = EXCEPT_EBREAK;
			end else if (w[31:20] == IMM12_MRET && m_mode) begin
				e.except = EXCEPT_MRET;
			end else begin
				ill = 1'b1;
			end
		end
		default: ill = 1'b1;
	endcase
	fault = (vld != 2'd0 && err[0]) || (vld == 2'd2 && err[1]);
	if (ill || e.starved || fault) begin
		e.rs1 = '0;
		e.rs2 = '0;
		e.rd = '0;
		e.memop = MEMOP_NONE;
		e.bcond = BCOND_NEVER;
		e.aluop = ALUOP_ADD;
		if (fault) begin
			e.except = EXCEPT_INSTR_FAULT;
		end else if (ill && !e.starved) begin
			e.except = EXCEPT_INSTR_ILLEGAL;
		end else begin
			e.except = EXCEPT_NONE;
		end
	end
	if (lock_prev) begin
		e.bcond = BCOND_NEVER;
	end
	return e;
endfunction

// Combinational CIR outputs of this cycle, then the PC and lock state after the next edge
function automatic void advance_pc(input logic xstall, input logic [1:0] vld, input logic jnow,
	input logic jne, input addr_t target, inout addr_t pc, inout logic lock_prev,
	output logic flush, output logic [1:0] use_cnt);
	logic stall;
	logic assert_lock;
	logic lock;
	stall = xstall || vld < 2'd2;
	assert_lock = jnow && jne && stall;
	lock = (lock_prev && stall) || assert_lock;
	flush = assert_lock && !lock_prev;
	use_cnt = stall ? 2'd0 : 2'd2;
	if ((jnow && !assert_lock) || (lock_prev && !stall)) begin
		pc = target;
	end else if (!stall && !lock) begin
		pc = pc + INSTR_STEP;
	end
	lock_prev = lock;
endfunction

// ==== tb_rv_decode.sv ====
// Random decode test with a fixed seed; cir_vld_i stays within 0..2 and jumps only come in the lock test
module tb_rv_decode
	import rv_decode_pkg::*;
();

localparam int unsigned CLK_PERIOD   = 40;
localparam int unsigned N_SEQ        = 150;
localparam int unsigned N_ALU        = 200;
localparam int unsigned N_MEM        = 200;
localparam int unsigned N_SQUASH     = 300;
localparam int unsigned N_LOCK       = 400;
localparam int unsigned TOTAL_CYCLES = 6 + N_SEQ + N_ALU + N_MEM + N_SQUASH + N_LOCK;

logic        clk;
logic        rst_n;
logic [31:0] cir_i;
logic [1:0]  cir_err_i;
logic [1:0]  cir_vld_i;
logic        m_mode_i;
logic        x_stall_i;
logic        jump_now_i;
addr_t       jump_target_i;
logic        jump_not_except_i;
logic [1:0]  cir_use_o;
logic        cir_flush_behind_o;
addr_t       pc_o;
logic        starved_o;
addr_t       imm_o;
reg_idx_t    rs1_o;
reg_idx_t    rs2_o;
reg_idx_t    rd_o;
alusrc_a_e   alusrc_a_o;
alusrc_b_e   alusrc_b_o;
aluop_e      aluop_o;
memop_e      memop_o;
bcond_e      branchcond_o;
addr_t       addr_offs_o;
logic        addr_is_regoffs_o;
except_e     except_o;

// Model state and counters
addr_t       pc_m;
logic        lock_m;
int unsigned checks;
int unsigned errors;
int unsigned test_errors;
logic [31:0] rnd;
int unsigned i;

rv_decode i_rv_decode (
	.clk                (clk),
	.rst_n              (rst_n),
	.cir_i              (cir_i),
	.cir_err_i          (cir_err_i),
	.cir_vld_i          (cir_vld_i),
	.cir_use_o          (cir_use_o),
	.cir_flush_behind_o (cir_flush_behind_o),
	.pc_o               (pc_o),
	.m_mode_i           (m_mode_i),
	.starved_o          (starved_o),
	.x_stall_i          (x_stall_i),
	.jump_now_i         (jump_now_i),
	.jump_target_i      (jump_target_i),
	.jump_not_except_i  (jump_not_except_i),
	.imm_o              (imm_o),
	.rs1_o              (rs1_o),
	.rs2_o              (rs2_o),
	.rd_o               (rd_o),
	.alusrc_a_o         (alusrc_a_o),
	.alusrc_b_o         (alusrc_b_o),
	.aluop_o            (aluop_o),
	.memop_o            (memop_o),
	.branchcond_o       (branchcond_o),
	.addr_offs_o        (addr_offs_o),
	.addr_is_regoffs_o  (addr_is_regoffs_o),
	.except_o           (except_o)
);

`include "tb_decode_model.svh"

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// ----------------------------------------------------------------------
// Stimulus and checking helpers
// ----------------------------------------------------------------------

// Classes 0 to 10 give legal words of one kind each and anything above is a raw random word
function automatic logic [31:0] random_instr(input int unsigned cls);
	logic [31:0] r;
	logic [6:0]  opc;
	int unsigned idx;
	r = $urandom;
	opc = r[6:0];
	case (cls)
		0: begin
			opc = OPC_OP;
			r[31:25] = r[30] ? FUNCT7_ALT : FUNCT7_BASE;
			if (r[30]) begin
				r[14:12] = r[12] ? 3'd5 : 3'd0;
			end
		end
		1: begin
			opc = OPC_OP_IMM;
			if (r[14:12] == 3'd1 || r[14:12] == 3'd5) begin
				r[31:25] = (r[14:12] == 3'd5 && r[30]) ? FUNCT7_ALT : FUNCT7_BASE;
			end
		end
		2: opc = OPC_LUI;
		3: opc = OPC_AUIPC;
		4: begin
			opc = OPC_LOAD;
			idx = $urandom % 5;
			r[14:12] = 3'((idx > 2) ? idx + 1 : idx);
		end
		5: begin
			opc = OPC_STORE;
			r[14:12] = 3'($urandom % 3);
		end
		6: begin
			opc = OPC_BRANCH;
			r[14:12] = (r[14:13] == 2'b01) ? {2'b00, r[12]} : r[14:12];
		end
		7: opc = OPC_JAL;
		8: begin
			opc = OPC_JALR;
			r[14:12] = 3'd0;
		end
		9: begin
			opc = OPC_MISC_MEM;
			r[19:7] = '0;
		end
		10: begin
			opc = OPC_SYSTEM;
			r[19:7] = '0;
			r[31:20] = r[1] ? IMM12_MRET : {11'd0, r[0]};
		end
		default: opc = r[6:0];
	endcase
	return {r[31:7], opc};
endfunction

task automatic check_value(input string name, input string what, input logic [31:0] exp,
	input logic [31:0] act);
	checks++;
	if (act !== exp) begin
		errors++;
		test_errors++;
		$display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
	end
endtask

// Drives one cycle on the falling edge and checks before the next rising edge
task automatic run_cycle(input string name, input logic [31:0] word, input logic [1:0] vld,
	input logic [1:0] err, input logic xstall, input logic jnow, input logic jne);
	exp_dec_t    e;
	logic        flush;
	logic [1:0]  use_cnt;
	logic [31:0] r;
	@(negedge clk);
	r = $urandom;
	cir_i = word;
	cir_vld_i = vld;
	cir_err_i = err;
	x_stall_i = xstall;
	jump_now_i = jnow;
	jump_not_except_i = jne;
	m_mode_i = r[0];
	jump_target_i = {r[31:2], 2'b00};
	#(CLK_PERIOD / 4);
	e = expected_decode(word, r[0], vld, err, lock_m);
	check_value(name, "pc", pc_m, pc_o);
	advance_pc(xstall, vld, jnow, jne, jump_target_i, pc_m, lock_m, flush, use_cnt);
	check_value(name, "cir_use", 32'(use_cnt), 32'(cir_use_o));
	check_value(name, "flush_behind", 32'(flush), 32'(cir_flush_behind_o));
	check_value(name, "starved", 32'(e.starved), 32'(starved_o));
	check_value(name, "rs1", 32'(e.rs1), 32'(rs1_o));
	check_value(name, "rs2", 32'(e.rs2), 32'(rs2_o));
	check_value(name, "rd", 32'(e.rd), 32'(rd_o));
	check_value(name, "alusrc_a", 32'(e.src_a), 32'(alusrc_a_o));
	check_value(name, "alusrc_b", 32'(e.src_b), 32'(alusrc_b_o));
	check_value(name, "aluop", 32'(e.aluop), 32'(aluop_o));
	check_value(name, "memop", 32'(e.memop), 32'(memop_o));
	check_value(name, "branchcond", 32'(e.bcond), 32'(branchcond_o));
	check_value(name, "regoffs", 32'(e.regoffs), 32'(addr_is_regoffs_o));
	check_value(name, "except", 32'(e.except), 32'(except_o));
	check_value(name, "imm", e.imm, imm_o);
	check_value(name, "addr_offs", e.offs, addr_offs_o);
endtask

task automatic end_test(input string name, input int unsigned cycles);
	$display("%s: %0d cycles, %0d errors", name, cycles, test_errors);
	test_errors = 0;
endtask

// ----------------------------------------------------------------------
// Test sequence
// ----------------------------------------------------------------------

initial begin
	rnd = $urandom(37444);
	rst_n = 1'b0;
	cir_i = '0;
	cir_err_i = '0;
	cir_vld_i = '0;
	m_mode_i = 1'b0;
	x_stall_i = 1'b0;
	jump_now_i = 1'b0;
	jump_target_i = '0;
	jump_not_except_i = 1'b0;
	pc_m = RESET_VECTOR;
	lock_m = 1'b0;
	checks = 0;
	errors = 0;
	test_errors = 0;
	repeat (5) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;

	// Runs first so the PC is followed from the reset vector
	for (i = 0; i < N_SEQ; i++) begin
		rnd = $urandom;
		run_cycle("sequencing", random_instr(rnd % 12),
			(rnd[9:8] == 2'd3) ? 2'd2 : rnd[9:8], 2'd0, rnd[12], 1'b0, 1'b0);
	end
	end_test("sequencing", N_SEQ);
	for (i = 0; i < N_ALU; i++) begin
		rnd = $urandom;
		run_cycle("alu_decode", random_instr(rnd % 4), 2'd2, 2'd0, 1'b0, 1'b0, 1'b0);
	end
	end_test("alu_decode", N_ALU);
	for (i = 0; i < N_MEM; i++) begin
		rnd = $urandom;
		run_cycle("mem_and_flow", random_instr(4 + rnd % 5), 2'd2, 2'd0, 1'b0, 1'b0, 1'b0);
	end
	end_test("mem_and_flow", N_MEM);
	for (i = 0; i < N_SQUASH; i++) begin
		rnd = $urandom;
		run_cycle("squash", random_instr(rnd % 14), (rnd[9:8] == 2'd3) ? 2'd2 : rnd[9:8],
			rnd[12] ? rnd[11:10] : 2'd0, 1'b0, 1'b0, 1'b0);
	end
	end_test("squash", N_SQUASH);
	// Mostly full CIR and few stalls so that locks are also released
	for (i = 0; i < N_LOCK; i++) begin
		rnd = $urandom;
		run_cycle("cir_lock", random_instr(rnd % 12),
			(rnd[9:8] == 2'd0) ? {1'b0, rnd[10]} : 2'd2, 2'd0,
			rnd[12] & rnd[13], rnd[14] & rnd[15], rnd[16] | rnd[17]);
	end
	end_test("cir_lock", N_LOCK);

	$display("Checks: %0d, errors: %0d", checks, errors);
	if (errors == 0) begin
		$display("No errors");
	end else begin
		$display("Errors found");
	end
	$finish;
end

initial begin
	#((TOTAL_CYCLES + 100) * CLK_PERIOD);
	$display("Timeout: the tests did not finish in the expected time");
	$display("Errors found");
	$finish;
end

endmodule

// ==== rv_decode.f ====
+incdir+.
rv_decode_pkg.sv
pc_cir_ctrl.sv
imm_gen.sv
instr_decoder.sv
rv_decode.sv
tb_rv_decode.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the decode testbench with Verilator, then judge the run from its log
verilator --binary --timing -f rv_decode.f --top-module tb_rv_decode \
	&& ./obj_dir/Vtb_rv_decode | tee sim.log \
	|| exit 1
grep -q "Errors found" sim.log && exit 1 || grep -q "No errors" sim.log
